// ==== npu_top.f ====
rtl/npu_pkg.sv
rtl/npu_ctrl_unit.sv
rtl/npu_reg_file.sv
rtl/npu_exec_unit.sv
rtl/npu_top.sv
verif/npu_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the npu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f npu_top.f \
    --top-module npu_top_tb \
    --Mdir obj_dir \
    -o npu_top_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/npu_top_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# pass only if the testbench printed the pass line
if echo "$sim_out" | grep -qx "NO ERRORS"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== verif/npu_top_tb.sv ====
`timescale 1ns/1ns

module npu_top_tb;

////////////////////////////////////////
// stimulus table
////////////////////////////////////////

// one host command with its idle cycles and expected read-back value
typedef struct packed {
    logic [3:0]         test;
    npu_pkg::cmd_word_t cmd;
    logic [7:0]         gap;
    npu_pkg::rf_data_t  exp;
} stim_entry_t;

logic                      clk = 1'b0;
logic                      i_rst_n;
npu_pkg::cmd_word_t        i_h2f_pio32;
logic                      i_h2f_write;
npu_pkg::rf_data_t         o_f2h_pio32;
logic                      o_f2h_write;
logic [npu_pkg::LED_W-1:0] o_led;

stim_entry_t       stim_q [$];
bit                table_built = 1'b0;
// reference model state
npu_pkg::rf_data_t model_rf [16];
int                model_done = 0;
// expected and captured read-back in command order
npu_pkg::rf_data_t exp_q [$];
npu_pkg::rf_data_t cap_q [$];
int                errors = 0;
int                checks = 0;
int                test_errors = 0;
int                clean_tests = 0;

npu_top u_dut (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_h2f_pio32 (i_h2f_pio32),
    .i_h2f_write (i_h2f_write),
    .o_f2h_pio32 (o_f2h_pio32),
    .o_f2h_write (o_f2h_write),
    .o_led       (o_led)
);

// 10 ns clock
always #5 clk = ~clk;

// read-back pulses sampled mid cycle
always @(negedge clk) begin
    if (i_rst_n === 1'b1 && o_f2h_write === 1'b1) begin
        cap_q.push_back(o_f2h_pio32);
    end
end

////////////////////////////////////////
// helpers
////////////////////////////////////////

function automatic npu_pkg::imm_t rand16();
    logic [31:0] r;
    r = $urandom();
    return r[15:0];
endfunction

function automatic npu_pkg::cmd_word_t make_cmd(input npu_pkg::opcode_t op, input int dst,
                                                input int src_a, input int src_b,
                                                input npu_pkg::imm_t imm);
    npu_pkg::cmd_word_t c;
    c.opcode = op;
    c.dst    = npu_pkg::rf_addr_t'(dst);
    c.src_a  = npu_pkg::rf_addr_t'(src_a);
    c.src_b  = npu_pkg::rf_addr_t'(src_b);
    c.imm    = imm;
    return c;
endfunction

task automatic add_entry(input int test, input npu_pkg::cmd_word_t cmd, input int gap,
                         input npu_pkg::rf_data_t exp);
    stim_entry_t e;
    e.test = 4'(test);
    e.cmd  = cmd;
    e.gap  = 8'(gap);
    e.exp  = exp;
    stim_q.push_back(e);
endtask

task automatic check_value(input string name, input npu_pkg::rf_data_t got,
                           input npu_pkg::rf_data_t exp);
    checks++;
    assert (got === exp) else begin
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        errors++;
        test_errors++;
    end
endtask

// opcode rules applied in command order to give the read-back value
function automatic npu_pkg::rf_data_t apply_model(input npu_pkg::cmd_word_t c);
    npu_pkg::rf_data_t a;
    npu_pkg::rf_data_t b;
    npu_pkg::rf_data_t rd;
    a  = model_rf[c.src_a];
    b  = model_rf[c.src_b];
    rd = '0;
    case (c.opcode)
        npu_pkg::OP_LOADI:  model_rf[c.dst] = {16'h0000, c.imm};
        npu_pkg::OP_LOADHI: model_rf[c.dst] = {c.imm, a[15:0]};
        npu_pkg::OP_ADD:    model_rf[c.dst] = a + b;
        npu_pkg::OP_SUB:    model_rf[c.dst] = a - b;
        npu_pkg::OP_MUL:    model_rf[c.dst] = 32'(a[15:0]) * 32'(b[15:0]);
        npu_pkg::OP_READ:   rd = a;
        default:            rd = '0;
    endcase
    // only real opcodes count as completed
    if (c.opcode >= npu_pkg::OP_LOADI && c.opcode <= npu_pkg::OP_READ) begin
        model_done++;
    end
    return rd;
endfunction

// starts on a falling edge and ends on a later one
task automatic issue(input stim_entry_t e);
    npu_pkg::rf_data_t rd;
    rd = apply_model(e.cmd);
    if (e.cmd.opcode == npu_pkg::OP_READ) begin
        check_value("table expectation", e.exp, rd);
        exp_q.push_back(rd);
    end
    i_h2f_pio32 = e.cmd;
    i_h2f_write = 1'b1;
    @(negedge clk);
    i_h2f_write = 1'b0;
    repeat (int'(e.gap)) @(negedge clk);
endtask

// drain the pipeline and then compare read-back and led count
task automatic finish_test(input int test);
    int waited;
    waited = 0;
    while (cap_q.size() < exp_q.size() && waited < 40) begin
        @(negedge clk);
        waited++;
    end
    waited = 0;
    while (int'(o_led) != model_done % 256 && waited < 10) begin
        @(negedge clk);
        waited++;
    end
    checks++;
    assert (cap_q.size() == exp_q.size()) else begin
        $display("test %0d: expected %0d read-back pulses but saw %0d",
                 test, exp_q.size(), cap_q.size());
        errors++;
        test_errors++;
    end
    while (cap_q.size() > 0 && exp_q.size() > 0) begin
        check_value("o_f2h_pio32", cap_q.pop_front(), exp_q.pop_front());
    end
    cap_q.delete();
    exp_q.delete();
    check_value("o_led", 32'(o_led), 32'(model_done % 256));
    $display("test %0d done: %0d errors", test, test_errors);
    if (test_errors == 0) begin
        clean_tests++;
    end
    test_errors = 0;
endtask

////////////////////////////////////////
// table contents
////////////////////////////////////////

task automatic build_table();
    npu_pkg::rf_data_t v [16];
    npu_pkg::imm_t     lo;
    npu_pkg::imm_t     hi;
    npu_pkg::imm_t     x;
    // test 1 reads every register as zero after reset
    for (int r = 0; r < 16; r++) begin
        add_entry(1, make_cmd(npu_pkg::OP_READ, 0, r, 0, '0), 0, '0);
    end
    // test 2 builds random full words from two loads
    for (int r = 1; r <= 8; r++) begin
        lo   = rand16();
        hi   = rand16();
        v[r] = {hi, lo};
        add_entry(2, make_cmd(npu_pkg::OP_LOADI, r, 0, 0, lo), 3, '0);
        add_entry(2, make_cmd(npu_pkg::OP_LOADHI, r, r, 0, hi), 3, '0);
        add_entry(2, make_cmd(npu_pkg::OP_READ, 0, r, 0, '0), 0, v[r]);
    end
    // test 3 wrap cases with r12 set to all ones
    add_entry(3, make_cmd(npu_pkg::OP_LOADI, 9, 0, 0, 16'h0000), 0, '0);
    add_entry(3, make_cmd(npu_pkg::OP_LOADI, 10, 0, 0, 16'h0001), 0, '0);
    add_entry(3, make_cmd(npu_pkg::OP_LOADI, 11, 0, 0, 16'hffff), 3, '0);
    add_entry(3, make_cmd(npu_pkg::OP_LOADHI, 12, 11, 0, 16'hffff), 3, '0);
    add_entry(3, make_cmd(npu_pkg::OP_SUB, 13, 9, 10, '0), 0, '0);
    add_entry(3, make_cmd(npu_pkg::OP_MUL, 14, 11, 11, '0), 0, '0);
    add_entry(3, make_cmd(npu_pkg::OP_ADD, 15, 12, 10, '0), 3, '0);
    add_entry(3, make_cmd(npu_pkg::OP_READ, 0, 13, 0, '0), 0, 32'hffff_ffff);
    add_entry(3, make_cmd(npu_pkg::OP_READ, 0, 14, 0, '0), 0, 32'hfffe_0001);
    add_entry(3, make_cmd(npu_pkg::OP_READ, 0, 15, 0, '0), 0, 32'h0000_0000);
    // random operands from test 2
    add_entry(3, make_cmd(npu_pkg::OP_ADD, 9, 1, 2, '0), 0, '0);
    add_entry(3, make_cmd(npu_pkg::OP_SUB, 10, 3, 4, '0), 0, '0);
    add_entry(3, make_cmd(npu_pkg::OP_MUL, 11, 5, 6, '0), 3, '0);
    add_entry(3, make_cmd(npu_pkg::OP_READ, 0, 9, 0, '0), 0, v[1] + v[2]);
    add_entry(3, make_cmd(npu_pkg::OP_READ, 0, 10, 0, '0), 0, v[3] - v[4]);
    add_entry(3, make_cmd(npu_pkg::OP_READ, 0, 11, 0, '0), 0,
              32'(v[5][15:0]) * 32'(v[6][15:0]));
    // test 4 runs independent commands on consecutive cycles
    for (int r = 1; r <= 8; r++) begin
        v[r] = {16'h0000, rand16()};
        add_entry(4, make_cmd(npu_pkg::OP_LOADI, r, 0, 0, v[r][15:0]), 0, '0);
    end
    for (int i = 1; i <= 4; i++) begin
        v[8 + i] = {16'h0000, rand16()};
        add_entry(4, make_cmd(npu_pkg::OP_READ, 0, i, 0, '0), 0, v[i]);
        add_entry(4, make_cmd(npu_pkg::OP_LOADI, 8 + i, 0, 0, v[8 + i][15:0]), 0, '0);
    end
    for (int r = 5; r <= 12; r++) begin
        add_entry(4, make_cmd(npu_pkg::OP_READ, 0, r, 0, '0), 0, v[r]);
    end
    // test 5 aims nop and unused codes at r1
    x = rand16();
    add_entry(5, make_cmd(npu_pkg::OP_LOADI, 1, 0, 0, x), 3, '0);
    add_entry(5, make_cmd(npu_pkg::OP_NOP, 1, 2, 3, rand16()), 0, '0);
    for (int op = 7; op < 16; op++) begin
        add_entry(5, make_cmd(npu_pkg::opcode_t'(op), 1, 2, 3, rand16()), (op == 15) ? 3 : 0,
                  '0);
    end
    add_entry(5, make_cmd(npu_pkg::OP_READ, 0, 1, 0, '0), 0, {16'h0000, x});
endtask

////////////////////////////////////////
// main sequence and watchdog
////////////////////////////////////////

initial begin
    i_rst_n     = 1'b0;
    i_h2f_write = 1'b0;
    i_h2f_pio32 = '0;
    void'($urandom(32'hb997));
    foreach (model_rf[i]) begin
        model_rf[i] = '0;
    end
    build_table();
    table_built = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;
    @(negedge clk);
    // idle state right after reset
    check_value("o_led", 32'(o_led), '0);
    checks++;
    assert (o_f2h_write === 1'b0 && cap_q.size() == 0) else begin
        $display("o_f2h_write pulsed before any read command");
        errors++;
        test_errors++;
    end
    for (int i = 0; i < stim_q.size(); i++) begin
        issue(stim_q[i]);
        if (i == stim_q.size() - 1 || stim_q[i + 1].test != stim_q[i].test) begin
            finish_test(int'(stim_q[i].test));
        end
    end
    $display("summary: %0d of 5 tests clean, %0d checks, %0d errors", clean_tests, checks,
             errors);
    if (errors == 0) begin
        $display("NO ERRORS");
    end else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

// limit from table length plus margin
initial begin : watchdog
    int limit;
    wait (table_built);
    limit = 100 + stim_q.size();
    foreach (stim_q[i]) begin
        limit += int'(stim_q[i].gap);
    end
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
end

endmodule

// ==== rtl/npu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module npu_top (
    input  logic                      clk,
    input  logic                      i_rst_n,

    // host to fabric mmio
    input  npu_pkg::cmd_word_t        i_h2f_pio32,
    input  logic                      i_h2f_write,

    // fabric to host mmio
    output npu_pkg::rf_data_t         o_f2h_pio32,
    output logic                      o_f2h_write,

    output logic [npu_pkg::LED_W-1:0] o_led
);

////////////////////////////////////////
// internal wires
////////////////////////////////////////

// ctrl unit to reg file
npu_pkg::rf_rd_req_t rd_req;
// ctrl unit to exec unit
npu_pkg::eu_op_t     eu_op;
// reg file read data
npu_pkg::rf_data_t   rd_data_a;
npu_pkg::rf_data_t   rd_data_b;
// exec unit write back
npu_pkg::rf_wr_t     wr;
// completion pulse
logic                cmd_done;

////////////////////////////////////////
// control unit
////////////////////////////////////////

npu_ctrl_unit u_ctrl_unit (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_h2f_pio32 (i_h2f_pio32),
    .i_h2f_write (i_h2f_write),
    .i_cmd_done  (cmd_done),
    .o_rd_req    (rd_req),
    .o_eu_op     (eu_op),
    .o_led       (o_led)
);

////////////////////////////////////////
// register file
////////////////////////////////////////

npu_reg_file u_reg_file (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_rd_req    (rd_req),
    .i_wr        (wr),
    .o_rd_data_a (rd_data_a),
    .o_rd_data_b (rd_data_b)
);

////////////////////////////////////////
// execution unit
////////////////////////////////////////

npu_exec_unit u_exec_unit (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_eu_op     (eu_op),
    .i_rd_data_a (rd_data_a),
    .i_rd_data_b (rd_data_b),
    .o_wr        (wr),
    .o_f2h_pio32 (o_f2h_pio32),
    .o_f2h_write (o_f2h_write),
    .o_cmd_done  (cmd_done)
);

endmodule

`default_nettype wire

// ==== rtl/npu_exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module npu_exec_unit (
    input  logic              clk,
    input  logic              i_rst_n,

    // op arrives one cycle before its operands
    input  npu_pkg::eu_op_t   i_eu_op,
    input  npu_pkg::rf_data_t i_rd_data_a,
    input  npu_pkg::rf_data_t i_rd_data_b,

    // write back to reg file
    output npu_pkg::rf_wr_t   o_wr,

    // host read back port
    output npu_pkg::rf_data_t o_f2h_pio32,
    output logic              o_f2h_write,

    // one pulse per finished command
    output logic              o_cmd_done
);

////////////////////////////////////////
// operand alignment
////////////////////////////////////////

// op delayed to line up with reg file data
npu_pkg::eu_op_t   op_q;
npu_pkg::rf_data_t result;
npu_pkg::rf_data_t mul_res;
logic              is_read;

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        op_q <= '0;
    end else begin
        op_q <= i_eu_op;
    end
end

////////////////////////////////////////
// result select
////////////////////////////////////////

// zero extended halves give a full 32 bit product
assign mul_res = {16'h0000, i_rd_data_a[15:0]} * {16'h0000, i_rd_data_b[15:0]};

assign is_read = (op_q.opcode == npu_pkg::OP_READ);

always_comb begin
    case (op_q.opcode)
        npu_pkg::OP_LOADI:  result = {16'h0000, op_q.imm};
        npu_pkg::OP_LOADHI: result = {op_q.imm, i_rd_data_a[15:0]};
        // add and sub wrap mod 2^32
        npu_pkg::OP_ADD:    result = i_rd_data_a + i_rd_data_b;
        npu_pkg::OP_SUB:    result = i_rd_data_a - i_rd_data_b;
        npu_pkg::OP_MUL:    result = mul_res;
        // read and nop have no result
        default:            result = '0;
    endcase
end

////////////////////////////////////////
// output registers
////////////////////////////////////////

// wb valid for one cycle after this edge
always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        o_wr        <= '0;
        o_f2h_write <= 1'b0;
        o_cmd_done  <= 1'b0;
    end else begin
        o_wr.valid  <= op_q.valid && !is_read;
        o_wr.addr   <= op_q.dst;
        o_wr.data   <= result;
        // read back pulse in the same cycle a wb would be
        o_f2h_write <= op_q.valid && is_read;
        o_cmd_done  <= op_q.valid;
    end
end

// host data holds after the pulse
always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        o_f2h_pio32 <= '0;
    end else if (op_q.valid && is_read) begin
        o_f2h_pio32 <= i_rd_data_a;
    end
end

endmodule

`default_nettype wire

// ==== rtl/npu_reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module npu_reg_file (
    input  logic                clk,
    input  logic                i_rst_n,

    // two read addresses from ctrl unit
    input  npu_pkg::rf_rd_req_t i_rd_req,

    // write back from exec unit
    input  npu_pkg::rf_wr_t     i_wr,

    // registered read data
    output npu_pkg::rf_data_t   o_rd_data_a,
    output npu_pkg::rf_data_t   o_rd_data_b
);

////////////////////////////////////////
// storage
////////////////////////////////////////

npu_pkg::rf_data_t mem [npu_pkg::RF_DEPTH];

// single write port
// reset brings every entry to zero
always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        for (int i = 0; i < npu_pkg::RF_DEPTH; i++) begin
            mem[i] <= '0;
        end
    end else if (i_wr.valid) begin
        mem[i_wr.addr] <= i_wr.data;
    end
end

////////////////////////////////////////
// read ports
////////////////////////////////////////

// synchronous reads
// same edge write to same addr still returns the old word
// idle cycles keep the last data so the ports do not toggle
always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        o_rd_data_a <= '0;
    end else if (i_rd_req.valid) begin
        o_rd_data_a <= mem[i_rd_req.addr_a];
    end
end

// port b mirrors port a
always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        o_rd_data_b <= '0;
    end else if (i_rd_req.valid) begin
        o_rd_data_b <= mem[i_rd_req.addr_b];
    end
end

endmodule

`default_nettype wire

// ==== rtl/npu_ctrl_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module npu_ctrl_unit (
    input  logic                      clk,
    input  logic                      i_rst_n,

    // host mmio command strobe
    input  npu_pkg::cmd_word_t        i_h2f_pio32,
    input  logic                      i_h2f_write,

    // completion pulse back from exec unit
    input  logic                      i_cmd_done,

    // operand fetch and op issue
    output npu_pkg::rf_rd_req_t       o_rd_req,
    output npu_pkg::eu_op_t           o_eu_op,

    // completed command count
    output logic [npu_pkg::LED_W-1:0] o_led
);

////////////////////////////////////////
// decode
////////////////////////////////////////

// high for opcodes that do real work
logic is_work;
// next values of the issue registers
npu_pkg::rf_rd_req_t rd_req_d;
npu_pkg::eu_op_t     eu_op_d;

always_comb begin
    case (i_h2f_pio32.opcode)
        npu_pkg::OP_LOADI,
        npu_pkg::OP_LOADHI,
        npu_pkg::OP_ADD,
        npu_pkg::OP_SUB,
        npu_pkg::OP_MUL,
        npu_pkg::OP_READ: is_work = 1'b1;
        // nop and unused codes
        default:          is_work = 1'b0;
    endcase
end

// read issued for every real op
// loadi ignores the data later
always_comb begin
    rd_req_d.valid  = i_h2f_write && is_work;
    rd_req_d.addr_a = i_h2f_pio32.src_a;
    rd_req_d.addr_b = i_h2f_pio32.src_b;
end

// op fields travel alongside the read
always_comb begin
    eu_op_d.valid  = i_h2f_write && is_work;
    eu_op_d.opcode = i_h2f_pio32.opcode;
    eu_op_d.dst    = i_h2f_pio32.dst;
    eu_op_d.imm    = i_h2f_pio32.imm;
end

////////////////////////////////////////
// issue registers
////////////////////////////////////////

// registered on the same edge that samples the strobe
always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        o_rd_req <= '0;
        o_eu_op  <= '0;
    end else begin
        o_rd_req <= rd_req_d;
        o_eu_op  <= eu_op_d;
    end
end

////////////////////////////////////////
// done counter
////////////////////////////////////////

// one count per done pulse
// wraps at 2^LED_W
always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        o_led <= '0;
    end else if (i_cmd_done) begin
        o_led <= o_led + 1'b1;
    end
end

endmodule

`default_nettype wire

// ==== rtl/npu_pkg.sv ====
package npu_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 4;
    localparam int IMM_W    = 16;
    localparam int OPCODE_W = 4;
    localparam int RF_DEPTH = 1 << ADDR_W;

    // width of the completed command counter on the leds
    localparam int LED_W = 8;

    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [ADDR_W-1:0]   rf_addr_t;
    typedef logic [DATA_W-1:0]   rf_data_t;
    typedef logic [IMM_W-1:0]    imm_t;

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////

    localparam opcode_t OP_NOP    = 4'd0;
    // dst gets zero extended imm
    localparam opcode_t OP_LOADI  = 4'd1;
    // dst gets imm on top of src a low half
    localparam opcode_t OP_LOADHI = 4'd2;
    localparam opcode_t OP_ADD    = 4'd3;
    localparam opcode_t OP_SUB    = 4'd4;
    // unsigned 16x16 product of the low halves
    localparam opcode_t OP_MUL    = 4'd5;
    // src a to host port, no write back
    localparam opcode_t OP_READ   = 4'd6;
    // codes 7 to 15 fall through as nop

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////

    // host command word, msb first
    typedef struct packed {
        opcode_t  opcode;
        rf_addr_t dst;
        rf_addr_t src_a;
        rf_addr_t src_b;
        imm_t     imm;
    } cmd_word_t;

    // ctrl unit to reg file
    typedef struct packed {
        logic     valid;
        rf_addr_t addr_a;
        rf_addr_t addr_b;
    } rf_rd_req_t;

    // ctrl unit to exec unit, one cycle ahead of operands
    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        rf_addr_t dst;
        imm_t     imm;
    } eu_op_t;

    // exec unit write back into reg file
    typedef struct packed {
        logic     valid;
        rf_addr_t addr;
        rf_data_t data;
    } rf_wr_t;

endpackage
